//--- include/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// IFB entries, credit check in the address generator needs at least 3
`define FE_IFB_DEPTH 4

// Direct-mapped BTB size, keep it a power of two
`define FE_BTB_ENTRIES 8

// First fetch address after reset
`define FE_RESET_VECTOR 32'h0000_0100

`endif

//--- hw/fe_types_pkg.sv
package fe_types_pkg;

    typedef logic [31:0] fe_addr_t;     // Byte address
    typedef logic [31:0] fe_instr_t;    // Raw instruction word

    // Result of one fetch
    typedef enum logic {
        FETCH_OK     = 1'b0,
        FETCH_BUSERR = 1'b1             // Bus answered with an error
    } fe_status_e;

    // One word held in the fetch buffer
    typedef struct packed {
        fe_instr_t  instr;
        fe_addr_t   addr;
        fe_status_e status;
        logic       pred;               // Next fetch was redirected by the BTB
    } ifb_entry_t;

    // Branch resolution from execute
    typedef struct packed {
        logic     valid;
        logic     taken;                // Taken writes, not taken invalidates
        fe_addr_t br_addr;
        fe_addr_t target;
    } pred_update_t;

    // Word handed to decode
    typedef struct packed {
        fe_instr_t  instr;
        fe_addr_t   addr;
        fe_status_e status;
        logic       pred;
    } fe_out_t;

endpackage

//--- hw/bus_pkg.sv
package bus_pkg;

    typedef logic [31:0] ahb_addr_t;
    typedef logic [31:0] ahb_data_t;

    // Only the two transfer types a single-beat read master needs
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        NONSEQ = 2'b10
    } htrans_e;

    // Master to slave, read only so no hwrite or hwdata
    typedef struct packed {
        ahb_addr_t haddr;
        htrans_e   htrans;
    } ahb_req_t;

    // Slave to master
    typedef struct packed {
        ahb_data_t hrdata;
        logic      hready;              // Data phase done, next address accepted
        logic      hresp;               // Error when high together with hready
    } ahb_rsp_t;

endpackage

//--- hw/fe_addr_gen.sv
`timescale 1ns/100ps
`include "fe_consts.svh"

module fe_addr_gen
    import fe_types_pkg::*, bus_pkg::*;
(
    input  logic                                 s_clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,        // Redirect from later stage
    input  fe_addr_t                             flush_addr_i,
    input  logic                                 pred_hit_i,     // BTB hit on FE0 address
    input  fe_addr_t                             pred_target_i,
    input  logic                                 pred_disable_i,
    input  logic [$clog2(`FE_IFB_DEPTH+1)-1:0]   ifb_count_i,    // Occupied IFB entries
    input  ahb_rsp_t                             ahb_rsp_i,
    output ahb_req_t                             ahb_req_o,
    output fe_addr_t                             lookup_addr_o,
    output logic                                 ifb_push_o,
    output ifb_entry_t                           ifb_entry_o
);
    localparam int CNT_W = $clog2(`FE_IFB_DEPTH + 1);

    // FE0 is the address phase
    typedef struct packed {
        fe_addr_t addr;
        logic     utd;                  // Request is live and its data is wanted
    } fe0_reg_t;

    // FE1 is the data phase, or a parked redirect while the bus stalls
    typedef struct packed {
        fe_addr_t addr;
        logic     utd;
        logic     pred;                 // Word was predicted taken
        logic     redir;                // addr holds a redirect waiting for FE0
    } fe1_reg_t;

    fe0_reg_t           fe0_q, fe0_d;
    fe1_reg_t           fe1_q, fe1_d;
    logic               bus_stall;
    logic               pred_taken;
    logic               ifb_available;
    logic [CNT_W-1:0]   ifb_free;
    logic [1:0]         in_flight;

    // Pending address phase cannot move while hready is low
    assign bus_stall  = fe0_q.utd & ~ahb_rsp_i.hready;
    assign pred_taken = fe0_q.utd & pred_hit_i & ~pred_disable_i;

    // Credit rule, free entries must exceed requests already on the bus
    assign ifb_free      = CNT_W'(`FE_IFB_DEPTH) - ifb_count_i;
    assign in_flight     = {1'b0, fe0_q.utd} + {1'b0, fe1_q.utd};
    assign ifb_available = ifb_free > CNT_W'(in_flight);

    assign ahb_req_o.haddr  = {fe0_q.addr[31:2], 2'b00};   // Word aligned fetch
    assign ahb_req_o.htrans = fe0_q.utd ? NONSEQ : IDLE;
    assign lookup_addr_o    = fe0_q.addr;

    // Completed data phase goes to the IFB unless it was dropped
    assign ifb_push_o         = ahb_rsp_i.hready & fe1_q.utd & ~flush_i;
    assign ifb_entry_o.instr  = ahb_rsp_i.hrdata;
    assign ifb_entry_o.addr   = fe1_q.addr;
    assign ifb_entry_o.status = ahb_rsp_i.hresp ? FETCH_BUSERR : FETCH_OK;
    assign ifb_entry_o.pred   = fe1_q.pred;

    always_comb begin : fe1_update
        fe1_d = fe1_q;                                  // Hold while data phase waits
        if (flush_i && bus_stall) begin
            // FE0 is frozen on the bus, park the flush target here
            fe1_d.addr  = flush_addr_i;
            fe1_d.utd   = 1'b0;
            fe1_d.pred  = 1'b0;
            fe1_d.redir = 1'b1;
        end else if (flush_i || (ahb_rsp_i.hready && fe1_q.redir)) begin
            fe1_d.utd   = 1'b0;                         // Whatever arrives next is stale
            fe1_d.pred  = 1'b0;
            fe1_d.redir = 1'b0;
        end else if (ahb_rsp_i.hready) begin
            fe1_d.addr  = fe0_q.addr;                   // FE0 accepted, enters data phase
            fe1_d.utd   = fe0_q.utd;
            fe1_d.pred  = pred_taken;
            fe1_d.redir = 1'b0;
        end
    end

    always_comb begin : fe0_update
        fe0_d = fe0_q;
        if (!bus_stall) begin
            if (flush_i) begin
                fe0_d.addr = flush_addr_i;              // IFB is emptied, no credit check
                fe0_d.utd  = 1'b1;
            end else if (fe1_q.redir) begin
                fe0_d.addr = fe1_q.addr;                // Parked redirect finally issues
                fe0_d.utd  = 1'b1;
            end else if (fe0_q.utd) begin
                // Request accepted, pick the following address
                fe0_d.addr = pred_taken ? pred_target_i : fe0_q.addr + 32'd4;
                fe0_d.utd  = ifb_available;
            end else begin
                fe0_d.utd  = ifb_available;             // Idle until buffer space frees
            end
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            fe0_q.addr  <= `FE_RESET_VECTOR;
            fe0_q.utd   <= 1'b0;
            fe1_q.utd   <= 1'b0;
            fe1_q.pred  <= 1'b0;
            fe1_q.redir <= 1'b0;
        end else begin
            fe0_q       <= fe0_d;
            fe1_q.utd   <= fe1_d.utd;
            fe1_q.pred  <= fe1_d.pred;
            fe1_q.redir <= fe1_d.redir;
        end
    end

    always_ff @(posedge s_clk_i) begin
        fe1_q.addr <= fe1_d.addr;                       // Only meaningful with utd or redir
    end

endmodule

//--- hw/btb_predictor.sv
`timescale 1ns/100ps
`include "fe_consts.svh"

module btb_predictor
    import fe_types_pkg::*;
(
    input  logic         s_clk_i,
    input  logic         rst_n_i,
    input  fe_addr_t     lookup_addr_i,     // FE0 address
    input  pred_update_t pred_upd_i,        // Resolution from execute
    output logic         hit_o,
    output fe_addr_t     target_o
);
    localparam int IDX_W = $clog2(`FE_BTB_ENTRIES);
    localparam int TAG_W = 32 - IDX_W - 2;

    typedef logic [IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0] btb_tag_t;

    typedef struct packed {
        btb_tag_t tag;
        fe_addr_t target;
    } btb_entry_t;

    logic [`FE_BTB_ENTRIES-1:0] valid_q;
    btb_entry_t                 entry_q [`FE_BTB_ENTRIES];
    btb_idx_t                   lk_idx;
    btb_tag_t                   lk_tag;
    btb_idx_t                   up_idx;
    btb_tag_t                   up_tag;
    logic                       up_match;

    // Index by word address, tag is the rest
    assign lk_idx = lookup_addr_i[IDX_W+1:2];
    assign lk_tag = lookup_addr_i[31:IDX_W+2];
    assign up_idx = pred_upd_i.br_addr[IDX_W+1:2];
    assign up_tag = pred_upd_i.br_addr[31:IDX_W+2];

    // Lookup is purely combinational so FE0 can redirect in the same cycle
    assign hit_o    = valid_q[lk_idx] & (entry_q[lk_idx].tag == lk_tag);
    assign target_o = entry_q[lk_idx].target;

    assign up_match = valid_q[up_idx] & (entry_q[up_idx].tag == up_tag);

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;                                  // Empty after reset
        end else if (pred_upd_i.valid) begin
            if (pred_upd_i.taken) begin
                valid_q[up_idx] <= 1'b1;                    // Taken allocates or replaces
            end else if (up_match) begin
                valid_q[up_idx] <= 1'b0;                    // Not taken drops own entry only
            end
        end
    end

    // Tag and target storage
    always_ff @(posedge s_clk_i) begin
        if (pred_upd_i.valid && pred_upd_i.taken) begin
            entry_q[up_idx].tag    <= up_tag;
            entry_q[up_idx].target <= pred_upd_i.target;
        end
    end

endmodule

//--- hw/ifb.sv
`timescale 1ns/100ps
`include "fe_consts.svh"

module ifb
    import fe_types_pkg::*;
(
    input  logic                                 s_clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,    // Drop all entries
    input  logic                                 push_i,
    input  ifb_entry_t                           entry_i,
    input  logic                                 pop_i,      // Decode ready
    output logic                                 valid_o,
    output fe_out_t                              out_o,
    output logic [$clog2(`FE_IFB_DEPTH+1)-1:0]   count_o
);
    localparam int DEPTH = `FE_IFB_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ifb_ptr_t;

    ifb_entry_t       mem_q [DEPTH];
    ifb_ptr_t         wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    ifb_entry_t       head;
    logic             do_push, do_pop;

    // Circular increment, depth need not be a power of two
    function automatic ifb_ptr_t ptr_inc(input ifb_ptr_t ptr);
        return (ptr == ifb_ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign valid_o = count_q != '0;
    assign count_o = count_q;
    assign do_push = push_i & ~flush_i;
    assign do_pop  = pop_i & valid_o & ~flush_i;    // Transfer on valid and ready

    assign head          = mem_q[rd_ptr_q];
    assign out_o.instr   = head.instr;
    assign out_o.addr    = head.addr;
    assign out_o.status  = head.status;
    assign out_o.pred    = head.pred;

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;        // Both or neither
            endcase
        end
    end

    // Entry storage, readable one cycle after the push
    always_ff @(posedge s_clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/100ps
`include "fe_consts.svh"

module fetch_stage
    import fe_types_pkg::*, bus_pkg::*;
(
    input  logic         s_clk_i,
    input  logic         rst_n_i,
    output ahb_req_t     ahb_req_o,          // Instruction bus master
    input  ahb_rsp_t     ahb_rsp_i,
    input  logic         flush_i,            // Redirect from later stage
    input  fe_addr_t     flush_addr_i,
    input  pred_update_t pred_upd_i,
    input  logic         pred_disable_i,
    output logic         fe_valid_o,         // Decode handshake
    input  logic         fe_ready_i,
    output fe_out_t      fe_out_o
);
    localparam int CNT_W = $clog2(`FE_IFB_DEPTH + 1);

    fe_addr_t         lookup_addr;
    logic             pred_hit;
    fe_addr_t         pred_target;
    logic             ifb_push;
    ifb_entry_t       ifb_entry;
    logic [CNT_W-1:0] ifb_count;

    // Address phase, data phase and bus control
    fe_addr_gen u_addr_gen (
        .s_clk_i        (s_clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .flush_addr_i   (flush_addr_i),
        .pred_hit_i     (pred_hit),
        .pred_target_i  (pred_target),
        .pred_disable_i (pred_disable_i),
        .ifb_count_i    (ifb_count),
        .ahb_rsp_i      (ahb_rsp_i),
        .ahb_req_o      (ahb_req_o),
        .lookup_addr_o  (lookup_addr),
        .ifb_push_o     (ifb_push),
        .ifb_entry_o    (ifb_entry)
    );

    btb_predictor u_btb (
        .s_clk_i       (s_clk_i),
        .rst_n_i       (rst_n_i),
        .lookup_addr_i (lookup_addr),   // Looked up with the FE0 address
        .pred_upd_i    (pred_upd_i),
        .hit_o         (pred_hit),
        .target_o      (pred_target)
    );

    // Fetched words waiting for decode
    ifb u_ifb (
        .s_clk_i (s_clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .push_i  (ifb_push),
        .entry_i (ifb_entry),
        .pop_i   (fe_ready_i),
        .valid_o (fe_valid_o),
        .out_o   (fe_out_o),
        .count_o (ifb_count)
    );

endmodule

//--- verif/ahb_mem_model.sv
`timescale 1ns/100ps

module ahb_mem_model
    import bus_pkg::*;
#(
    parameter int unsigned SEED = 1
) (
    input  logic     s_clk_i,
    input  logic     rst_n_i,
    input  ahb_req_t ahb_req_i,
    output ahb_rsp_t ahb_rsp_o
);
    logic       busy_q;                 // Data phase in progress
    logic [1:0] wait_q;                 // Wait states left in this data phase
    ahb_addr_t  addr_q;
    logic       done;
    logic       err_region;

    // Address XOR pattern rotated left by the word index bits
    function automatic ahb_data_t word_at(input ahb_addr_t a);
        ahb_data_t x;
        x = a ^ 32'hA5A5_0000;
        return (x << a[6:2]) | (x >> (6'd32 - a[6:2]));
    endfunction

    assign done       = busy_q & (wait_q == 2'd0);
    assign err_region = addr_q[31:8] == 24'h00_0080;   // 0x8000 up to 0x80FF

    assign ahb_rsp_o.hready = ~busy_q | (wait_q == 2'd0);
    assign ahb_rsp_o.hresp  = done & err_region;       // One cycle error response
    assign ahb_rsp_o.hrdata = (done && !err_region) ? word_at(addr_q) : '0;

    initial begin : slave_proc
        void'($urandom(SEED));
        forever begin
            @(posedge s_clk_i);
            if (!rst_n_i) begin
                busy_q <= 1'b0;
                wait_q <= 2'd0;
                addr_q <= '0;
            end else if (ahb_rsp_o.hready) begin
                busy_q <= ahb_req_i.htrans == NONSEQ;      // Address phase accepted
                addr_q <= ahb_req_i.haddr;
                wait_q <= 2'($urandom % 4);                 // 0 to 3 wait states
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

endmodule

//--- verif/tb_fetch_stage.sv
`timescale 1ns/100ps
`include "fe_consts.svh"

module tb_fetch_stage
    import fe_types_pkg::*, bus_pkg::*;
();
    localparam int unsigned SEED    = 3576;
    localparam int          IDX_W   = $clog2(`FE_BTB_ENTRIES);
    localparam int          N_SEQ   = 24;       // Words per test
    localparam int          N_BP    = 40;
    localparam int          N_FLUSH = 10;
    localparam int          N_BTB   = 12;
    localparam int          N_ERR   = 16;
    localparam int          N_TOTAL = N_SEQ + N_BP + 2 * N_FLUSH + 3 * N_BTB + N_ERR;

    logic         clk = 1'b0;
    logic         rst_n;
    ahb_req_t     ahb_req;
    ahb_rsp_t     ahb_rsp;
    logic         flush;
    fe_addr_t     flush_addr;
    pred_update_t pred_upd;
    logic         pred_disable;
    logic         fe_valid;
    logic         fe_ready;
    fe_out_t      fe_out;
    int unsigned  accepted;                 // Words taken by decode so far

    // Testbench copy of the programmed BTB
    logic         btb_v   [`FE_BTB_ENTRIES];
    fe_addr_t     btb_br  [`FE_BTB_ENTRIES];
    fe_addr_t     btb_tgt [`FE_BTB_ENTRIES];

    always #20 clk = ~clk;                  // 40 ns period

    fetch_stage dut (
        .s_clk_i        (clk),
        .rst_n_i        (rst_n),
        .ahb_req_o      (ahb_req),
        .ahb_rsp_i      (ahb_rsp),
        .flush_i        (flush),
        .flush_addr_i   (flush_addr),
        .pred_upd_i     (pred_upd),
        .pred_disable_i (pred_disable),
        .fe_valid_o     (fe_valid),
        .fe_ready_i     (fe_ready),
        .fe_out_o       (fe_out)
    );

    ahb_mem_model #(.SEED(SEED)) u_mem (
        .s_clk_i   (clk),
        .rst_n_i   (rst_n),
        .ahb_req_i (ahb_req),
        .ahb_rsp_o (ahb_rsp)
    );

    // Expected memory word from the XOR pattern rotated by address bits 6:2
    function automatic fe_instr_t mem_word(input fe_addr_t a);
        logic [63:0] dbl;
        dbl = {a ^ 32'hA5A5_0000, a ^ 32'hA5A5_0000} << a[6:2];
        return dbl[63:32];
    endfunction

    function automatic fe_status_e expected_status(input fe_addr_t a);
        return (a >= 32'h0000_8000 && a <= 32'h0000_80FF) ? FETCH_BUSERR : FETCH_OK;
    endfunction

    function automatic logic predicted_at(input fe_addr_t a);
        logic [IDX_W-1:0] idx;
        idx = a[2 +: IDX_W];
        return !pred_disable && btb_v[idx] && (btb_br[idx][31:2] == a[31:2]);
    endfunction

    // Reference next fetch address
    function automatic fe_addr_t next_fetch_addr(input fe_addr_t a);
        return predicted_at(a) ? btb_tgt[a[2 +: IDX_W]] : a + 32'd4;
    endfunction

    task automatic end_with_failure();
        $display("Result: FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic instr_compare(input string name, input fe_instr_t act, input fe_instr_t exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, act, exp);
            end_with_failure();
        end
    endtask

    task automatic addr_compare(input string name, input fe_addr_t act, input fe_addr_t exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, act, exp);
            end_with_failure();
        end
    endtask

    task automatic status_compare(input string name, input fe_status_e act, input fe_status_e exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s got %s expected %s", $time, name, act.name(), exp.name());
            end_with_failure();
        end
    endtask

    task automatic flag_compare(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, act, exp);
            end_with_failure();
        end
    endtask

    task automatic htrans_compare(input string name, input htrans_e act, input htrans_e exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s got %s expected %s", $time, name, act.name(), exp.name());
            end_with_failure();
        end
    endtask

    task automatic wait_for_words(input int unsigned n);
        int unsigned target;
        target = accepted + n;
        while (accepted < target) @(negedge clk);
    endtask

    // One cycle flush pulse from a later stage
    task automatic redirect_fetch(input fe_addr_t a);
        @(negedge clk);
        flush      = 1'b1;
        flush_addr = a;
        @(negedge clk);
        flush      = 1'b0;
    endtask

    task automatic apply_btb_update(input fe_addr_t br, input fe_addr_t tgt, input logic taken);
        logic [IDX_W-1:0] idx;
        idx = br[2 +: IDX_W];
        @(negedge clk);
        pred_upd.valid   = 1'b1;
        pred_upd.taken   = taken;
        pred_upd.br_addr = br;
        pred_upd.target  = tgt;
        if (taken) begin
            btb_v[idx]   = 1'b1;              // Taken replaces whatever sat there
            btb_br[idx]  = br;
            btb_tgt[idx] = tgt;
        end else if (btb_v[idx] && btb_br[idx] == br) begin
            btb_v[idx]   = 1'b0;
        end
        @(negedge clk);
        pred_upd = '0;
    endtask

    // Every word decode takes is checked against the reference stream
    initial begin : compare_outputs
        fe_addr_t exp_addr;
        exp_addr = `FE_RESET_VECTOR;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                exp_addr = `FE_RESET_VECTOR;
            end else if (flush) begin
                exp_addr = flush_addr;        // Buffer dropped so the stream restarts here
            end else if (fe_valid && fe_ready) begin
                addr_compare("fe_out_o.addr", fe_out.addr, exp_addr);
                status_compare("fe_out_o.status", fe_out.status, expected_status(exp_addr));
                if (expected_status(exp_addr) == FETCH_OK) begin
                    instr_compare("fe_out_o.instr", fe_out.instr, mem_word(exp_addr));
                end
                flag_compare("fe_out_o.pred", fe_out.pred, predicted_at(exp_addr));
                exp_addr = next_fetch_addr(exp_addr);
                accepted++;
            end
        end
    end

    initial begin : watchdog
        repeat (200 * N_TOTAL) @(posedge clk);
        $display("Timeout after %0d cycles, decode got %0d words", 200 * N_TOTAL, accepted);
        end_with_failure();
    end

    initial begin : run_tests
        int unsigned target;
        void'($urandom(SEED));
        rst_n        = 1'b0;
        flush        = 1'b0;
        flush_addr   = '0;
        pred_upd     = '0;
        pred_disable = 1'b0;
        fe_ready     = 1'b1;
        accepted     = 0;
        for (int i = 0; i < `FE_BTB_ENTRIES; i++) begin
            btb_v[i] = 1'b0;
        end
        repeat (8) @(negedge clk);
        htrans_compare("ahb_req_o.htrans", ahb_req.htrans, IDLE);     // Quiet bus in reset
        flag_compare("fe_valid_o", fe_valid, 1'b0);
        rst_n = 1'b1;
        @(negedge clk);
        htrans_compare("ahb_req_o.htrans", ahb_req.htrans, NONSEQ);   // Fetch starts at once
        addr_compare("ahb_req_o.haddr", ahb_req.haddr, `FE_RESET_VECTOR);

        wait_for_words(N_SEQ);                 // Plain sequential stream

        target = accepted + N_BP;              // Random back-pressure with long stalls
        while (accepted < target) begin
            @(negedge clk);
            if ($urandom % 16 == 0) begin
                fe_ready = 1'b0;
                repeat ($urandom % 24 + 8) @(negedge clk);
            end
            fe_ready = 1'($urandom % 2);
        end
        fe_ready = 1'b1;

        redirect_fetch(32'h0000_1000);         // Flush while streaming
        wait_for_words(N_FLUSH);
        fe_ready = 1'b0;                       // Flush with a full buffer
        repeat (12) @(negedge clk);
        redirect_fetch(32'h0000_2000);
        fe_ready = 1'b1;
        wait_for_words(N_FLUSH);

        fe_ready = 1'b0;                       // 0x200 jumps to 0x400 and 0x408 loops back
        apply_btb_update(32'h0000_0200, 32'h0000_0400, 1'b1);
        apply_btb_update(32'h0000_0408, 32'h0000_0200, 1'b1);
        redirect_fetch(32'h0000_01F0);
        fe_ready = 1'b1;
        wait_for_words(N_BTB);
        fe_ready     = 1'b0;
        pred_disable = 1'b1;                   // Same entries but sequential order
        redirect_fetch(32'h0000_01F8);
        fe_ready = 1'b1;
        wait_for_words(N_BTB);
        fe_ready     = 1'b0;
        pred_disable = 1'b0;
        apply_btb_update(32'h0000_0200, 32'h0000_0000, 1'b0);
        redirect_fetch(32'h0000_01F8);
        fe_ready = 1'b1;
        wait_for_words(N_BTB);

        redirect_fetch(32'h0000_7FF0);         // Run into the error region
        wait_for_words(N_ERR);

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
hw/fe_types_pkg.sv
hw/bus_pkg.sv
hw/fe_addr_gen.sv
hw/btb_predictor.sv
hw/ifb.sv
hw/fetch_stage.sv
verif/ahb_mem_model.sv
verif/tb_fetch_stage.sv
